// File: design/flit_settings.svh
// sizing macros for the flit buffer, included by the packages and the testbench
`ifndef FLIT_SETTINGS_SVH
`define FLIT_SETTINGS_SVH

// storage slots in the ordering array
`define FLIT_SLOTS 24

// per-port source id, the flow id adds the port bit on top
`define FLIT_SRC_W 5
`define FLIT_ID_W (`FLIT_SRC_W + 1)

// qos tag carried with every flit
`define FLIT_QOS_W 2

// four 32-bit words of flit data
`define FLIT_PAYLOAD_W 128

// older same-flow count, wide enough for every slot of one flow
`define FLIT_SEQ_W 5

`endif

// File: design/flit_pkg.sv
// flit field types shared by the ingress ports, the slot storage and the egress port
`include "flit_settings.svh"

package flit_pkg;

    // source id as seen on one ingress port
    typedef logic [`FLIT_SRC_W-1:0] src_id_t;

    // port bit above the source id
    // 0 for port a, 1 for port b
    typedef logic [`FLIT_ID_W-1:0] flow_id_t;

    // qos rides along, order does not depend on it
    typedef logic [`FLIT_QOS_W-1:0] qos_t;

    // flit data, word 0 in the low bits
    typedef logic [`FLIT_PAYLOAD_W-1:0] payload_t;

endpackage

// File: design/slot_pkg.sv
// bookkeeping types of the slot array, imported by the ordering storage
`include "flit_settings.svh"

package slot_pkg;

    // one bit per slot, bit 0 is slot 0
    typedef logic [`FLIT_SLOTS-1:0] slot_mask_t;

    // binary slot number
    typedef logic [$clog2(`FLIT_SLOTS)-1:0] slot_idx_t;

    // older flits of the same flow still held
    // zero marks the head of its flow
    typedef logic [`FLIT_SEQ_W-1:0] seq_cnt_t;

endpackage

// File: design/port_arbiter.sv
// ingress arbiter that alternates between ports a and b and hands the accepted flit to the slots
`timescale 1ns/1ps

module port_arbiter import flit_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_valid_a,
    input  logic     i_valid_b,
    input  src_id_t  i_src_a,
    input  src_id_t  i_src_b,
    input  qos_t     i_qos_a,
    input  qos_t     i_qos_b,
    input  payload_t i_payload_a,
    input  payload_t i_payload_b,
    input  logic     i_full,
    output logic     o_ready_a,
    output logic     o_ready_b,
    output logic     o_store,
    output flow_id_t o_store_id,
    output qos_t     o_store_qos,
    output payload_t o_store_payload
);

    logic port_sel;  // 0 port a, 1 port b
    logic sel_nxt;
    logic take_a;
    logic take_b;

    // both valid flips the choice, else follow the lone valid port
    assign sel_nxt = (i_valid_a && i_valid_b) ? ~port_sel : i_valid_b;

    assign take_a = i_valid_a && o_ready_a;
    assign take_b = i_valid_b && o_ready_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port_sel  <= 1'b0;
            o_ready_a <= 1'b0;
            o_ready_b <= 1'b0;
            o_store   <= 1'b0;
        end else begin
            port_sel  <= sel_nxt;
            // ready is offered one cycle ahead to the chosen port only
            o_ready_a <= ~sel_nxt && ~i_full;
            o_ready_b <= sel_nxt && ~i_full;
            o_store   <= take_a || take_b;  // single cycle store strobe
        end
    end

    // accepted flit, the port bit lands on top of the source id
    always_ff @(posedge clk) begin
        if (take_b) begin
            o_store_id      <= {1'b1, i_src_b};
            o_store_qos     <= i_qos_b;
            o_store_payload <= i_payload_b;
        end else if (take_a) begin
            o_store_id      <= {1'b0, i_src_a};
            o_store_qos     <= i_qos_a;
            o_store_payload <= i_payload_a;
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_ready_a && o_ready_b))
        else $error("port_arbiter: ready offered to both ports");

endmodule

// File: design/order_slot_array.sv
// slot storage that keeps per-flow arrival order and offers the lowest head slot for egress
`timescale 1ns/1ps
`include "flit_settings.svh"

module order_slot_array import flit_pkg::*, slot_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_store,
    input  flow_id_t i_store_id,
    input  qos_t     i_store_qos,
    input  payload_t i_store_payload,
    input  logic     i_take,
    output logic     o_full,
    output logic     o_head_valid,
    output flow_id_t o_head_id,
    output qos_t     o_head_qos,
    output payload_t o_head_payload
);

    localparam int CNT_W = $clog2(`FLIT_SLOTS) + 1;

    slot_mask_t slot_vld;
    seq_cnt_t   slot_seq  [`FLIT_SLOTS];
    flow_id_t   slot_id   [`FLIT_SLOTS];
    qos_t       slot_qos  [`FLIT_SLOTS];
    payload_t   slot_data [`FLIT_SLOTS];

    slot_mask_t free_mask;
    slot_mask_t free_sel;   // lowest free slot, one-hot
    slot_mask_t vote_mask;  // slots at the head of their flow
    slot_mask_t head_sel;   // lowest voting slot, one-hot
    slot_mask_t count_down;
    slot_idx_t  free_idx;
    slot_idx_t  head_idx;
    seq_cnt_t   store_seq;
    logic [CNT_W-1:0] fill_cnt;

    assign free_mask = ~slot_vld;
    assign free_sel  = free_mask & (~free_mask + slot_mask_t'(1));
    assign head_sel  = vote_mask & (~vote_mask + slot_mask_t'(1));

    always_comb begin
        free_idx = '0;
        head_idx = '0;
        fill_cnt = CNT_W'(i_store);  // the store in flight already owns a slot
        for (int i = 0; i < `FLIT_SLOTS; i++) begin
            vote_mask[i] = slot_vld[i] && (slot_seq[i] == '0);
            if (free_sel[i]) free_idx = slot_idx_t'(i);
            if (head_sel[i]) head_idx = slot_idx_t'(i);
            if (slot_vld[i]) fill_cnt = fill_cnt + CNT_W'(1);
        end
    end

    assign o_head_valid   = |vote_mask;
    assign o_head_id      = slot_id[head_idx];
    assign o_head_qos     = slot_qos[head_idx];
    assign o_head_payload = slot_data[head_idx];

    // one slot stays back for a flit the arbiter may be accepting right now
    assign o_full = fill_cnt >= CNT_W'(`FLIT_SLOTS - 1);

    // older flits of the incoming flow, minus the head leaving this cycle
    always_comb begin
        store_seq = '0;
        for (int i = 0; i < `FLIT_SLOTS; i++) begin
            count_down[i] = i_take && slot_vld[i] && !head_sel[i] &&
                            (slot_id[i] == o_head_id);
            if (slot_vld[i] && (slot_id[i] == i_store_id) && !(i_take && head_sel[i]))
                store_seq = store_seq + seq_cnt_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_vld <= '0;
            for (int i = 0; i < `FLIT_SLOTS; i++) begin
                slot_seq[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FLIT_SLOTS; i++) begin
                if (i_store && free_sel[i]) begin
                    slot_vld[i] <= 1'b1;
                    slot_seq[i] <= store_seq;
                end else if (i_take && head_sel[i]) begin
                    slot_vld[i] <= 1'b0;
                end else if (count_down[i]) begin
                    slot_seq[i] <= slot_seq[i] - seq_cnt_t'(1);  // one step closer to head
                end
            end
        end
    end

    // flit fields, only read while the slot is valid
    always_ff @(posedge clk) begin
        if (i_store) begin
            slot_id[free_idx]   <= i_store_id;
            slot_qos[free_idx]  <= i_store_qos;
            slot_data[free_idx] <= i_store_payload;
        end
    end

    a_store_room: assert property (@(posedge clk) disable iff (!rst_n)
        i_store |-> |free_mask)
        else $error("order_slot_array: store with no free slot");

    a_take_head: assert property (@(posedge clk) disable iff (!rst_n)
        i_take |-> o_head_valid)
        else $error("order_slot_array: take without a head");

    // a flow never has two heads at once
    for (genvar g = 0; g < `FLIT_SLOTS; g++) begin : g_head_chk
        slot_mask_t twin_vote;
        always_comb begin
            for (int j = 0; j < `FLIT_SLOTS; j++) begin
                twin_vote[j] = vote_mask[j] && (j != g) && (slot_id[j] == slot_id[g]);
            end
        end
        a_one_head: assert property (@(posedge clk) disable iff (!rst_n)
            vote_mask[g] |-> (twin_vote == '0))
            else $error("order_slot_array: two heads for flow %0h", slot_id[g]);
    end

endmodule

// File: design/egress_stage.sv
// egress register that pulls the next head from the slots and holds it on port c
`timescale 1ns/1ps

module egress_stage import flit_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_head_valid,
    input  flow_id_t i_head_id,
    input  qos_t     i_head_qos,
    input  payload_t i_head_payload,
    input  logic     i_ready_c,
    output logic     o_take,
    output logic     o_valid_c,
    output flow_id_t o_id_c,
    output qos_t     o_qos_c,
    output payload_t o_payload_c
);

    logic xfer_c;

    assign xfer_c = o_valid_c && i_ready_c;

    // pull a head when the register is empty or drains this cycle
    assign o_take = i_head_valid && (!o_valid_c || i_ready_c);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid_c <= 1'b0;
        end else if (o_take) begin
            o_valid_c <= 1'b1;
        end else if (xfer_c) begin
            o_valid_c <= 1'b0;  // sent and nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (o_take) begin
            o_id_c      <= i_head_id;
            o_qos_c     <= i_head_qos;
            o_payload_c <= i_head_payload;
        end
    end

    // stalled flit must not change under the receiver
    a_hold_c: assert property (@(posedge clk) disable iff (!rst_n)
        o_valid_c && !i_ready_c |=> o_valid_c && $stable(o_id_c) &&
                                    $stable(o_qos_c) && $stable(o_payload_c))
        else $error("egress_stage: port c changed while stalled");

endmodule

// File: design/flit_buffer_top.sv
// flit buffer top with two ingress ports and one ordered egress port
`timescale 1ns/1ps

module flit_buffer_top import flit_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_valid_a,
    input  src_id_t  i_src_a,
    input  qos_t     i_qos_a,
    input  payload_t i_payload_a,
    output logic     o_ready_a,
    input  logic     i_valid_b,
    input  src_id_t  i_src_b,
    input  qos_t     i_qos_b,
    input  payload_t i_payload_b,
    output logic     o_ready_b,
    input  logic     i_ready_c,
    output logic     o_valid_c,
    output flow_id_t o_id_c,
    output qos_t     o_qos_c,
    output payload_t o_payload_c
);

    // arbiter to slots
    logic     store;
    flow_id_t store_id;
    qos_t     store_qos;
    payload_t store_payload;
    logic     full;

    // slots to egress
    logic     head_valid;
    flow_id_t head_id;
    qos_t     head_qos;
    payload_t head_payload;
    logic     take;

    port_arbiter u_port_arbiter (
        .clk(clk), .rst_n(rst_n),
        .i_valid_a(i_valid_a), .i_valid_b(i_valid_b),
        .i_src_a(i_src_a), .i_src_b(i_src_b),
        .i_qos_a(i_qos_a), .i_qos_b(i_qos_b),
        .i_payload_a(i_payload_a), .i_payload_b(i_payload_b),
        .i_full(full), .o_ready_a(o_ready_a), .o_ready_b(o_ready_b),
        .o_store(store), .o_store_id(store_id),
        .o_store_qos(store_qos), .o_store_payload(store_payload)
    );

    order_slot_array u_order_slot_array (
        .clk(clk), .rst_n(rst_n),
        .i_store(store), .i_store_id(store_id),
        .i_store_qos(store_qos), .i_store_payload(store_payload),
        .i_take(take), .o_full(full), .o_head_valid(head_valid),
        .o_head_id(head_id), .o_head_qos(head_qos), .o_head_payload(head_payload)
    );

    egress_stage u_egress_stage (
        .clk(clk), .rst_n(rst_n),
        .i_head_valid(head_valid), .i_head_id(head_id),
        .i_head_qos(head_qos), .i_head_payload(head_payload),
        .i_ready_c(i_ready_c), .o_take(take), .o_valid_c(o_valid_c),
        .o_id_c(o_id_c), .o_qos_c(o_qos_c), .o_payload_c(o_payload_c)
    );

endmodule

// File: bench/tb_flit_buffer.sv
// testbench for flit_buffer_top, drives both ingress ports and checks per-flow order on port c
`timescale 1ns/1ps
`include "flit_settings.svh"

module tb_flit_buffer import flit_pkg::*; ();

    localparam int FLOWS   = 1 << `FLIT_ID_W;
    localparam int PLANNED = 20 + 30 + 120 + 40;  // flits over all phases
    localparam int LIMIT   = 40 * PLANNED + 200;

    typedef struct packed {
        qos_t     qos;
        payload_t payload;
    } flit_t;

    logic clk, rst_n;
    logic i_valid_a, i_valid_b, i_ready_c;
    src_id_t i_src_a, i_src_b;
    qos_t i_qos_a, i_qos_b;
    payload_t i_payload_a, i_payload_b;
    logic o_ready_a, o_ready_b, o_valid_c;
    flow_id_t o_id_c;
    qos_t o_qos_c;
    payload_t o_payload_c;

    flit_t model_q [FLOWS][$];  // one queue per flow id
    logic [31:0] lfsr = 32'h8742;
    int cycle_cnt = 0;
    int quota, issued, accepted = 0;
    int test_id = 0;
    int last_test = 0;
    int low_run, base, got;
    string test_name = "reset";
    logic busy_a = 0, busy_b = 0, xfer_a = 0, xfer_b = 0;
    logic last_port = 0;
    logic prev_stall = 0;
    flow_id_t hold_id;
    qos_t hold_qos;
    payload_t hold_payload;

    flit_buffer_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic fb;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // next flit the model expects for this flow
    function automatic flit_t expected_flit(input flow_id_t id);
        return model_q[id][0];
    endfunction

    function automatic bit model_empty();
        for (int f = 0; f < FLOWS; f++) begin
            if (model_q[f].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic bit drained();
        return issued == quota && !busy_a && !busy_b && model_empty() && !o_valid_c;
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error: %s flag expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_id(input string name, input flow_id_t exp, input flow_id_t act);
        if (exp !== act) begin
            $display("error: %s id expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_qos(input string name, input qos_t exp, input qos_t act);
        if (exp !== act) begin
            $display("error: %s qos expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_payload(input string name, input payload_t exp, input payload_t act);
        if (exp !== act) begin
            $display("error: %s payload expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_egress();
        flit_t exp;
        if (test_id == 2)  // port a only, so the port bit must be clear
            check_id(test_name, {1'b0, o_id_c[`FLIT_SRC_W-1:0]}, o_id_c);
        if (model_q[o_id_c].size() == 0) begin
            $display("egress sent a flit of flow %h that was never accepted", o_id_c);
            abort_run();
        end else begin
            exp = expected_flit(o_id_c);
            check_qos(test_name, exp.qos, o_qos_c);
            check_payload(test_name, exp.payload, o_payload_c);
            void'(model_q[o_id_c].pop_front());
        end
    endtask

    task automatic record_ingress(input logic port, input flow_id_t id, input flit_t f);
        if (test_id == 3 && last_test == 3 && port == last_port) begin
            $display("two ingress transfers in a row came from port %0d", port);
            abort_run();
        end
        model_q[id].push_back(f);
        last_port = port;
        last_test = test_id;
        accepted++;
    endtask

    // one falling edge of stimulus, a source keeps its flit until transfer
    task automatic step_inputs(input bit use_a, input bit use_b, input bit rand_valid,
                               input int ready_mode);
        @(negedge clk);
        if (busy_a && xfer_a) busy_a = 1'b0;
        if (busy_b && xfer_b) busy_b = 1'b0;
        if (!busy_a) begin
            if (use_a && issued < quota && (!rand_valid || take_bits(1) != '0)) begin
                i_src_a     = src_id_t'(take_bits(2));  // four sources per port
                i_qos_a     = qos_t'(take_bits(2));
                i_payload_a = {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
                i_valid_a   = 1'b1;
                busy_a      = 1'b1;
                issued++;
            end else i_valid_a = 1'b0;
        end
        if (!busy_b) begin
            if (use_b && issued < quota && (!rand_valid || take_bits(1) != '0)) begin
                i_src_b     = src_id_t'(take_bits(2));
                i_qos_b     = qos_t'(take_bits(2));
                i_payload_b = {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
                i_valid_b   = 1'b1;
                busy_b      = 1'b1;
                issued++;
            end else i_valid_b = 1'b0;
        end
        if (ready_mode == 2) i_ready_c = take_bits(1) != '0;
        else i_ready_c = (ready_mode == 1);
    endtask

    task automatic run_phase(input int id, input string name, input int n, input bit use_a,
                             input bit use_b, input bit rand_valid, input int ready_mode);
        test_id   = id;
        test_name = name;
        quota     = n;
        issued    = 0;
        do step_inputs(use_a, use_b, rand_valid, ready_mode);
        while (!drained());
    endtask

    // monitor and compare, sampled on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (o_ready_a && o_ready_b) begin
                $display("both ingress readies were high in the same cycle");
                abort_run();
            end
            if (o_valid_c && i_ready_c) compare_egress();
            if (prev_stall) begin  // stalled flit must not move
                check_id(test_name, hold_id, o_id_c);
                check_qos(test_name, hold_qos, o_qos_c);
                check_payload(test_name, hold_payload, o_payload_c);
            end
            prev_stall   = o_valid_c && !i_ready_c;
            hold_id      = o_id_c;
            hold_qos     = o_qos_c;
            hold_payload = o_payload_c;
            xfer_a = i_valid_a && o_ready_a;
            xfer_b = i_valid_b && o_ready_b;
            if (xfer_a) record_ingress(1'b0, {1'b0, i_src_a}, {i_qos_a, i_payload_a});
            if (xfer_b) record_ingress(1'b1, {1'b1, i_src_b}, {i_qos_b, i_payload_b});
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout, the run hung after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    initial begin
        rst_n = 1'b0;
        i_valid_a = 1'b0;
        i_valid_b = 1'b0;
        i_src_a = '0;
        i_src_b = '0;
        i_qos_a = '0;
        i_qos_b = '0;
        i_payload_a = '0;
        i_payload_b = '0;
        i_ready_c = 1'b0;
        repeat (5) @(negedge clk);
        check_flag("reset ready a", 1'b0, o_ready_a);
        check_flag("reset ready b", 1'b0, o_ready_b);
        check_flag("reset valid c", 1'b0, o_valid_c);
        rst_n = 1'b1;

        run_phase(2, "single port", 20, 1'b1, 1'b0, 1'b0, 1);
        run_phase(3, "alternate", 30, 1'b1, 1'b1, 1'b0, 1);
        run_phase(4, "random order", 120, 1'b1, 1'b1, 1'b1, 2);

        // port c held low until both readies stay down
        test_id   = 5;
        test_name = "backpressure";
        quota     = 40;
        issued    = 0;
        base      = accepted;
        low_run   = 0;
        while (low_run < 20) begin
            step_inputs(1'b1, 1'b1, 1'b0, 0);
            if (!o_ready_a && !o_ready_b) low_run++;
            else low_run = 0;
        end
        got = accepted - base;  // slots plus egress, arbiter may hold one more
        if (got < `FLIT_SLOTS + 1 || got > `FLIT_SLOTS + 2) begin
            $display("error: %s accepted expected %0d to %0d actual %0d", test_name,
                     `FLIT_SLOTS + 1, `FLIT_SLOTS + 2, got);
            abort_run();
        end

        // port c idle for longer than store, vote and take need
        low_run = 0;
        while (low_run < 4) begin
            step_inputs(1'b1, 1'b1, 1'b0, 1);
            if (issued == quota && !busy_a && !busy_b && !o_valid_c) low_run++;
            else low_run = 0;
        end

        if (model_empty()) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("model still holds flits after the final drain");
            abort_run();
        end
    end

endmodule

// File: all.f
+incdir+design
design/flit_pkg.sv
design/slot_pkg.sv
design/port_arbiter.sv
design/order_slot_array.sv
design/egress_stage.sv
design/flit_buffer_top.sv
bench/tb_flit_buffer.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_flit_buffer
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
